//--- rtl/cache_pkg.sv
package cache_pkg;

    // Word and address widths on the CPU side
    localparam int WORD_BITS      = 16;
    localparam int ADDR_BITS      = 16;

    // Address splits into tag, set index and word offset
    localparam int OFF_BITS       = 2;
    localparam int IDX_BITS       = 1;
    localparam int TAG_BITS       = ADDR_BITS - IDX_BITS - OFF_BITS;
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFF_BITS;

    // Cache geometry
    localparam int LINE_WORDS     = 1 << OFF_BITS;
    localparam int NUM_SETS       = 1 << IDX_BITS;
    localparam int NUM_WAYS       = 2;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [ADDR_BITS-1:0]      waddr_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [IDX_BITS-1:0]       idx_t;
    typedef logic [OFF_BITS-1:0]       off_t;
    typedef logic [LINE_ADDR_BITS-1:0] laddr_t;

    // Word 0 sits in the lowest 16 bits
    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef struct packed {
        logic   rd;
        logic   wr;
        waddr_t addr;
        word_t  wdata;
    } cpu_req_t;

    function automatic off_t addr_off(waddr_t a);
        return a[OFF_BITS-1:0];
    endfunction

    function automatic idx_t addr_idx(waddr_t a);
        return a[OFF_BITS +: IDX_BITS];
    endfunction

    function automatic tag_t addr_tag(waddr_t a);
        return a[ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic laddr_t line_addr(waddr_t a);
        return a[ADDR_BITS-1:OFF_BITS];
    endfunction

endpackage

//--- rtl/mem_pkg.sv
package mem_pkg;

    localparam int MEM_WORD_BITS  = 16;
    localparam int MEM_LINE_WORDS = 4;
    // Memory is addressed in whole lines
    localparam int MEM_LADDR_BITS = 14;

    typedef logic [MEM_WORD_BITS-1:0]  mem_word_t;
    typedef mem_word_t [MEM_LINE_WORDS-1:0] mem_line_t;
    typedef logic [MEM_LADDR_BITS-1:0] mem_laddr_t;
    typedef logic [MEM_LINE_WORDS-1:0] mem_mask_t;

    // Read and write are single-cycle pulses
    typedef struct packed {
        logic       rd;
        logic       wr;
        mem_laddr_t addr;
        mem_line_t  data;
        mem_mask_t  mask;
    } mem_req_t;

    // Read line is valid in the ack cycle
    typedef struct packed {
        logic      ack;
        mem_line_t rdata;
    } mem_rsp_t;

endpackage

//--- rtl/cache_array.sv
`timescale 1ns/1ps

module cache_array (
    input  logic              clk,
    input  logic              reset_n,
    input  cache_pkg::waddr_t i_addr,
    output logic              o_hit,
    output cache_pkg::word_t  o_hit_word,
    output cache_pkg::line_t  o_merged_line,
    input  cache_pkg::word_t  i_wdata,
    input  logic              i_touch,
    input  logic              i_write_word,
    input  logic              i_fill,
    input  cache_pkg::line_t  i_fill_line
);
    import cache_pkg::*;

    // Storage per set and way
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    tag_t                tags  [NUM_SETS][NUM_WAYS];
    line_t               lines [NUM_SETS][NUM_WAYS];
    // Way to replace next in each set
    logic                lru   [NUM_SETS];

    idx_t                idx;
    tag_t                tag;
    off_t                off;
    logic [NUM_WAYS-1:0] way_hit;
    logic                hit_way;
    logic                victim;
    line_t               hit_line;

    assign idx = addr_idx(i_addr);
    assign tag = addr_tag(i_addr);
    assign off = addr_off(i_addr);

    // Tag compare in both ways of the addressed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid[idx][w] && (tags[idx][w] == tag);
        end
    end

    assign o_hit    = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_line = lines[idx][hit_way];

    assign o_hit_word = hit_line[off];

    // Hit line with the write word dropped in at the offset
    always_comb begin
        o_merged_line      = hit_line;
        o_merged_line[off] = i_wdata;
    end

    // Empty way first, otherwise the LRU way
    always_comb begin
        if (!valid[idx][0]) begin
            victim = 1'b0;
        end else if (!valid[idx][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru[idx];
        end
    end

    // Valid and LRU state
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                lru[s]   <= 1'b0;
            end
        end else if (i_fill) begin
            valid[idx][victim] <= 1'b1;
            lru[idx]           <= ~victim;
        end else if (i_touch || i_write_word) begin
            // Other way becomes the next to go
            lru[idx] <= ~hit_way;
        end
    end

    // Tag and line contents
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tags[idx][victim]  <= tag;
            lines[idx][victim] <= i_fill_line;
        end else if (i_write_word) begin
            lines[idx][hit_way] <= o_merged_line;
        end
    end

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    // Latency of the attached memory
    parameter int MEM_LATENCY = 4
) (
    input  logic                clk,
    input  logic                reset_n,
    input  cache_pkg::cpu_req_t i_cpu_req,
    output logic                o_ready,
    output cache_pkg::word_t    o_rdata,
    output mem_pkg::mem_req_t   o_mem_req,
    input  mem_pkg::mem_rsp_t   i_mem_rsp
);
    import cache_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_READY,
        ST_LOOKUP,
        ST_MISS_WAIT,
        ST_WMISS_WAIT
    } state_t;

    state_t    state;
    cpu_req_t  req_q;
    // Line write-through still in flight
    logic      bg_pending;

    logic      mem_rd_q;
    logic      mem_wr_q;
    laddr_t    mem_addr_q;
    line_t     mem_data_q;
    mem_mask_t mem_mask_q;

    logic      hit;
    word_t     hit_word;
    line_t     merged_line;
    logic      mem_free;
    logic      do_touch;
    logic      do_fill;
    logic      issue_rd;
    logic      issue_line;
    logic      issue_word;

    cache_array u_cache_array (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_addr        (req_q.addr),
        .o_hit         (hit),
        .o_hit_word    (hit_word),
        .o_merged_line (merged_line),
        .i_wdata       (req_q.wdata),
        .i_touch       (do_touch),
        .i_write_word  (issue_line),
        .i_fill        (do_fill),
        .i_fill_line   (i_mem_rsp.rdata)
    );

    assign o_ready = (state == ST_READY);

    // Memory can take a new request once the background write acks
    assign mem_free = !bg_pending || i_mem_rsp.ack;

    // Lookup decision
    always_comb begin
        do_touch   = 1'b0;
        do_fill    = 1'b0;
        issue_rd   = 1'b0;
        issue_line = 1'b0;
        issue_word = 1'b0;
        case (state)
            ST_LOOKUP: begin
                if (req_q.rd) begin
                    if (hit) begin
                        do_touch = 1'b1;
                    end else begin
                        issue_rd = mem_free;
                    end
                end else if (hit) begin
                    issue_line = mem_free;
                end else begin
                    issue_word = mem_free;
                end
            end
            ST_MISS_WAIT: do_fill = i_mem_rsp.ack;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= ST_READY;
            bg_pending <= 1'b0;
            mem_rd_q   <= 1'b0;
            mem_wr_q   <= 1'b0;
        end else begin
            mem_rd_q <= issue_rd;
            mem_wr_q <= issue_line || issue_word;
            if (i_mem_rsp.ack) begin
                bg_pending <= 1'b0;
            end
            if (issue_line) begin
                bg_pending <= 1'b1;
            end
            case (state)
                ST_READY: begin
                    if (i_cpu_req.rd || i_cpu_req.wr) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    // Stays here while memory is busy with a write-through
                    if (do_touch || issue_line) begin
                        state <= ST_READY;
                    end else if (issue_rd) begin
                        state <= ST_MISS_WAIT;
                    end else if (issue_word) begin
                        state <= ST_WMISS_WAIT;
                    end
                end
                ST_MISS_WAIT, ST_WMISS_WAIT: begin
                    if (i_mem_rsp.ack) begin
                        state <= ST_READY;
                    end
                end
                default: state <= ST_READY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && (i_cpu_req.rd || i_cpu_req.wr)) begin
            req_q <= i_cpu_req;
        end
        if (do_touch) begin
            o_rdata <= hit_word;
        end else if (do_fill) begin
            o_rdata <= i_mem_rsp.rdata[addr_off(req_q.addr)];
        end
        if (issue_rd || issue_line || issue_word) begin
            mem_addr_q <= line_addr(req_q.addr);
            // Single word goes out in every slot and the mask picks one
            mem_data_q <= issue_word ? {LINE_WORDS{req_q.wdata}} : merged_line;
            mem_mask_q <= issue_word ? mem_mask_t'(1) << addr_off(req_q.addr) : '1;
        end
    end

    assign o_mem_req = '{
        rd:   mem_rd_q,
        wr:   mem_wr_q,
        addr: mem_addr_q,
        data: mem_data_q,
        mask: mem_mask_q
    };

endmodule

//--- rtl/main_memory.sv
`timescale 1ns/1ps

module main_memory #(
    // At least 2
    parameter int MEM_LATENCY = 4,
    // Power of two so that addresses wrap
    parameter int MEM_LINES   = 256
) (
    input  logic              clk,
    input  logic              reset_n,
    input  mem_pkg::mem_req_t i_req,
    output mem_pkg::mem_rsp_t o_rsp
);
    import mem_pkg::*;

    localparam int        IDX_W    = $clog2(MEM_LINES);
    localparam int        CNT_W    = $clog2(MEM_LATENCY + 1);
    localparam mem_word_t INIT_KEY = 16'h5A5A;

    mem_line_t        mem [MEM_LINES];
    mem_req_t         req_q;
    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             due;
    logic             ack_q;
    mem_line_t        rdata_q;
    logic [IDX_W-1:0] line_idx;

    // Last counting cycle before the access lands on the next edge
    assign due      = busy && (cnt == CNT_W'(1));
    assign line_idx = req_q.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            ack_q <= 1'b0;
            cnt   <= '0;
        end else begin
            ack_q <= due;
            if (due) begin
                busy <= 1'b0;
            end else if (!busy && (i_req.rd || i_req.wr)) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(MEM_LATENCY - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && (i_req.rd || i_req.wr)) begin
            req_q <= i_req;
        end
    end

    // Word at word address a reads back as a ^ 5A5A after reset
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int l = 0; l < MEM_LINES; l++) begin
                for (int w = 0; w < MEM_LINE_WORDS; w++) begin
                    mem[l][w] <= mem_word_t'(l * MEM_LINE_WORDS + w) ^ INIT_KEY;
                end
            end
        end else if (due) begin
            if (req_q.wr) begin
                for (int w = 0; w < MEM_LINE_WORDS; w++) begin
                    if (req_q.mask[w]) begin
                        mem[line_idx][w] <= req_q.data[w];
                    end
                end
            end else begin
                rdata_q <= mem[line_idx];
            end
        end
    end

    assign o_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

//--- rtl/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem #(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_LINES   = 256
) (
    input  logic                clk,
    input  logic                reset_n,
    input  cache_pkg::cpu_req_t i_cpu_req,
    output logic                o_ready,
    output cache_pkg::word_t    o_rdata
);
    import mem_pkg::*;

    // Cache to memory link
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    cache_ctrl #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_cache_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_cpu_req (i_cpu_req),
        .o_ready   (o_ready),
        .o_rdata   (o_rdata),
        .o_mem_req (mem_req),
        .i_mem_rsp (mem_rsp)
    );

    main_memory #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_LINES   (MEM_LINES)
    ) u_main_memory (
        .clk     (clk),
        .reset_n (reset_n),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
    );

endmodule

//--- verification/cache_subsystem_sva.sv
`timescale 1ns/1ps

module cache_subsystem_sva #(
    parameter int MEM_LATENCY = 4
) (
    input logic                clk,
    input logic                reset_n,
    input cache_pkg::cpu_req_t i_cpu_req,
    input logic                i_ready,
    input logic                i_hit,
    input mem_pkg::mem_req_t   i_mem_req,
    input mem_pkg::mem_rsp_t   i_mem_rsp
);
    int unsigned assert_fails = 0;
    logic        outstanding;
    logic        mem_pulse;

    assign mem_pulse = i_mem_req.rd || i_mem_req.wr;

    // Memory request in flight from its pulse until the ack
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            outstanding <= 1'b0;
        end else if (mem_pulse) begin
            outstanding <= 1'b1;
        end else if (i_mem_rsp.ack) begin
            outstanding <= 1'b0;
        end
    end

    reset_values: assert property (@(posedge clk)
        !reset_n |=> (i_ready && !i_mem_req.rd && !i_mem_req.wr))
    else begin
        $error("o_ready or memory pulse wrong after reset");
        assert_fails++;
    end

    single_request: assert property (@(posedge clk) disable iff (!reset_n)
        mem_pulse |-> !outstanding)
    else begin
        $error("memory request issued while one is outstanding");
        assert_fails++;
    end

    rd_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        i_mem_req.rd |=> !i_mem_req.rd)
    else begin
        $error("memory read pulse longer than one cycle");
        assert_fails++;
    end

    wr_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        i_mem_req.wr |=> !i_mem_req.wr)
    else begin
        $error("memory write pulse longer than one cycle");
        assert_fails++;
    end

    ack_latency: assert property (@(posedge clk) disable iff (!reset_n)
        mem_pulse |-> ##MEM_LATENCY i_mem_rsp.ack)
    else begin
        $error("memory ack not at the fixed latency");
        assert_fails++;
    end

    // Accepted read that hits in lookup is back in ready one edge later
    read_hit_time: assert property (@(posedge clk) disable iff (!reset_n)
        (i_ready && i_cpu_req.rd) ##1 i_hit |=> i_ready)
    else begin
        $error("read hit did not complete in 2 cycles");
        assert_fails++;
    end

endmodule

bind cache_ctrl cache_subsystem_sva #(.MEM_LATENCY(MEM_LATENCY)) u_sva (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_cpu_req (i_cpu_req),
    .i_ready   (o_ready),
    .i_hit     (hit),
    .i_mem_req (o_mem_req),
    .i_mem_rsp (i_mem_rsp)
);

//--- verification/cache_subsystem_tb.sv
`timescale 1ns/1ps

module cache_subsystem_tb;
    import cache_pkg::*;

    localparam int MEM_LATENCY = 4;
    localparam int MEM_LINES   = 256;
    localparam int MEM_WORDS   = MEM_LINES * LINE_WORDS;
    localparam int NUM_RANDOM  = 200;
    // Each access at most waits out a write-through and then does its own
    localparam int NUM_ACCESS  = NUM_RANDOM + 30;
    localparam int TIMEOUT     = NUM_ACCESS * (2 * MEM_LATENCY + 4) + 240;

    logic     clk = 1'b0;
    logic     reset_n;
    cpu_req_t i_cpu_req;
    logic     o_ready;
    word_t    o_rdata;

    int       cycle = 0;
    int       errors = 0;
    int       tests_ok = 0;
    int       tests_bad = 0;
    int       test_base = 0;
    // First acceptance edge at which no write-through is in flight
    int       mem_idle_edge = 0;

    word_t    shadow_mem [MEM_WORDS];
    logic     sh_valid [NUM_SETS][NUM_WAYS];
    tag_t     sh_tag   [NUM_SETS][NUM_WAYS];
    logic     sh_lru   [NUM_SETS];

    cache_subsystem #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_LINES   (MEM_LINES)
    ) UUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_cpu_req (i_cpu_req),
        .o_ready   (o_ready),
        .o_rdata   (o_rdata)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycle);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic int total_errors();
        return errors + int'(UUT.u_cache_ctrl.u_sva.assert_fails);
    endfunction

    // Way holding the address in the shadow cache or -1 on a miss
    function automatic int find_way(waddr_t a);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (sh_valid[a[2]][w] && sh_tag[a[2]][w] == a[15:3]) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic note_access(input waddr_t a, input logic fill);
        int way;
        way = find_way(a);
        if (way < 0 && fill) begin
            if (!sh_valid[a[2]][0]) begin
                way = 0;
            end else if (!sh_valid[a[2]][1]) begin
                way = 1;
            end else begin
                way = int'(sh_lru[a[2]]);
            end
            sh_valid[a[2]][way] = 1'b1;
            sh_tag[a[2]][way]   = a[15:3];
        end
        // LRU bit points at the way not just used
        if (way >= 0) begin
            sh_lru[a[2]] = (way == 0);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    // Strobe until the acceptance edge, then count edges until o_ready is back
    task automatic run_access(input logic rd, input waddr_t a, input word_t wd,
                              output int edges, output int acc_edge);
        i_cpu_req = '{rd: rd, wr: !rd, addr: a, wdata: wd};
        @(posedge clk);
        #1;
        i_cpu_req = '0;
        acc_edge  = cycle;
        edges     = 1;
        while (!o_ready) begin
            @(posedge clk);
            #1;
            edges++;
        end
    endtask

    task automatic read_word(input waddr_t a, output logic was_hit);
        int   edges;
        int   acc;
        logic predict;
        predict = (find_way(a) >= 0);
        run_access(1'b1, a, '0, edges, acc);
        was_hit = (edges == 2);
        check_word("o_rdata", shadow_mem[a % MEM_WORDS], o_rdata);
        check_true(predict ? edges == 2 : edges > 2,
                   $sformatf("read of %h took %0d edges, hit expected %0b", a, edges, predict));
        note_access(a, 1'b1);
    endtask

    task automatic write_word(input waddr_t a, input word_t d, output logic was_hit);
        int   edges;
        int   acc;
        logic predict;
        predict = (find_way(a) >= 0);
        run_access(1'b0, a, d, edges, acc);
        was_hit = (edges == 2);
        check_true((predict && acc >= mem_idle_edge) ? edges == 2 : edges > 2,
                   $sformatf("write of %h took %0d edges, hit expected %0b", a, edges, predict));
        // Write-through issues at the edge where o_ready returns
        if (predict) begin
            mem_idle_edge = acc + edges - 1 + MEM_LATENCY;
        end
        shadow_mem[a % MEM_WORDS] = d;
        note_access(a, 1'b0);
    endtask

    task automatic end_test(input string name);
        if (total_errors() == test_base) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: FAILED with %0d errors", name, total_errors() - test_base);
        end
        test_base = total_errors();
    endtask

    initial begin
        logic   was_hit;
        waddr_t a;
        void'($urandom(32'h4b67));
        reset_n   = 1'b0;
        i_cpu_req = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow_mem[i] = word_t'(i) ^ 16'h5A5A;
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;

        check_true(o_ready, "o_ready is low after reset");
        read_word(16'h0001, was_hit);
        check_true(!was_hit, "first read after reset did not miss");
        check_word("o_rdata", 16'h0001 ^ 16'h5A5A, o_rdata);
        end_test("reset and first read");

        read_word(16'h0003, was_hit);
        check_true(was_hit, "read in the same line did not hit");
        end_test("read hit in same line");

        // Tags A, B and C all map to set 1
        read_word(16'h0104, was_hit);
        read_word(16'h0124, was_hit);
        read_word(16'h0105, was_hit);
        check_true(was_hit, "line A not kept after filling B");
        read_word(16'h0144, was_hit);
        check_true(!was_hit, "line C hit before it was read");
        read_word(16'h0106, was_hit);
        check_true(was_hit, "line A evicted instead of B");
        read_word(16'h0125, was_hit);
        check_true(!was_hit, "line B still cached after C");
        end_test("LRU replacement");

        write_word(16'h0002, 16'hBEEF, was_hit);
        check_true(was_hit, "write to a cached word was not a 2-cycle hit");
        read_word(16'h0002, was_hit);
        check_true(was_hit, "read after write hit missed");
        read_word(16'h0008, was_hit);
        read_word(16'h0010, was_hit);
        read_word(16'h0002, was_hit);
        check_true(!was_hit, "written line was not evicted");
        end_test("write hit and write-through");

        write_word(16'h0205, 16'h1234, was_hit);
        check_true(!was_hit, "write to an uncached word did not stall");
        read_word(16'h0205, was_hit);
        check_true(!was_hit, "write miss allocated a line");
        end_test("write miss without allocate");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = waddr_t'($urandom % 32);
            if ($urandom % 2) begin
                write_word(a, word_t'($urandom), was_hit);
            end else begin
                read_word(a, was_hit);
            end
        end
        end_test("random mix");

        $display("Tests: %0d passed, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0 && total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- cache_subsystem.f
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/main_memory.sv
rtl/cache_subsystem.sv
verification/cache_subsystem_sva.sv
verification/cache_subsystem_tb.sv
